//--- include/l1_cache_consts.svh
// cache geometry, maintenance op code fields and memory line width
`ifndef L1_CACHE_CONSTS_SVH
`define L1_CACHE_CONSTS_SVH

// direct mapped, 64 sets of 16 byte lines
`define L1_INDEX_W  6
`define L1_OFFSET_W 4
`define L1_TAG_W    22
`define L1_LINE_W   128

// op code bit 0 selects the target cache
`define OP_TGT_ICACHE 1'b0
`define OP_TGT_DCACHE 1'b1

// op code bit 1 selects the invalidation kind
`define OP_KIND_IDX_INV 1'b0
`define OP_KIND_HIT_INV 1'b1

`endif

//--- source/l1_cache_pkg.sv
// maintenance address word with its hit and index views
`default_nettype none
`include "l1_cache_consts.svh"

package l1_cache_pkg;

    // hit-invalidate compares the tag, index-invalidate ignores it
    typedef union packed {
        struct packed {
            logic [`L1_TAG_W-1:0]    tag;
            logic [`L1_INDEX_W-1:0]  index;
            logic [`L1_OFFSET_W-1:0] offset;
        } hit_view;
        struct packed {
            logic [`L1_TAG_W-1:0]    unused;
            logic [`L1_INDEX_W-1:0]  index;
            logic [`L1_OFFSET_W-1:0] offset;
        } index_view;
    } cache_op_addr_u;

endpackage

`default_nettype wire

//--- source/cache_opctr.sv
// cache maintenance controller: accept, dispatch to one cache, wait for ack
`timescale 1ns/1ps
`default_nettype none
`include "l1_cache_consts.svh"

module cache_opctr
    import l1_cache_pkg::*;
(
    input  logic           clk_i,
    input  logic           arst_n_i,
    input  logic           op_valid_i,
    input  logic [1:0]     op_code_i,
    input  logic [31:0]    op_addr_i,
    input  logic           ic_ack_i,
    input  logic           dc_ack_i,
    output logic           ic_op_o,
    output logic           dc_op_o,
    output logic           op_kind_o,
    output cache_op_addr_u op_addr_o,
    output logic           op_busy_o,
    output logic           op_done_o
);
    logic           busy_q;
    logic           strobe_q;
    logic           done_q;
    logic [1:0]     code_q;
    cache_op_addr_u addr_q;
    logic           tgt_dc;
    logic           ack;

    assign tgt_dc = (code_q[0] == `OP_TGT_DCACHE);
    assign ack    = tgt_dc ? dc_ack_i : ic_ack_i;

    assign ic_op_o   = strobe_q && !tgt_dc;
    assign dc_op_o   = strobe_q && tgt_dc;
    assign op_kind_o = code_q[1];
    assign op_addr_o = addr_q;
    assign op_busy_o = busy_q;
    assign op_done_o = done_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q   <= 1'b0;
            strobe_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            strobe_q <= 1'b0;
            done_q   <= 1'b0;
            if (op_valid_i && !busy_q) begin
                busy_q   <= 1'b1;
                strobe_q <= 1'b1; // one pulse to the target
            end else if (busy_q && ack) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // held stable for the cache while busy
    always_ff @(posedge clk_i) begin
        if (op_valid_i && !busy_q) begin
            code_q <= op_code_i;
            addr_q <= op_addr_i;
        end
    end

    a_one_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ic_op_o || dc_op_o) |-> (busy_q && !(ic_op_o && dc_op_o)));

endmodule

`default_nettype wire

//--- source/icache.sv
// direct-mapped read-only instruction cache with line refill and invalidation
`timescale 1ns/1ps
`default_nettype none
`include "l1_cache_consts.svh"

module icache
    import l1_cache_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  if_valid_i,
    input  logic [31:0]           if_addr_i,
    output logic                  if_ready_o,
    output logic                  if_rdata_valid_o,
    output logic [31:0]           if_rdata_o,
    input  logic                  op_i,
    input  logic                  op_kind_i,
    input  cache_op_addr_u        op_addr_i,
    output logic                  op_ack_o,
    output logic                  mem_req_o,
    output logic [31:0]           mem_addr_o,
    input  logic                  mem_addr_ok_i,
    input  logic                  mem_data_ok_i,
    input  logic [`L1_LINE_W-1:0] mem_rline_i
);
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ  = 2'd1;
    localparam logic [1:0] S_WAIT = 2'd2;

    logic [1:0]                  state_q;
    logic [31:0]                 addr_q;
    logic                        op_pend_q;
    logic [(1<<`L1_INDEX_W)-1:0] valid_q;
    logic [`L1_TAG_W-1:0]        tag_q  [1<<`L1_INDEX_W];
    logic [`L1_LINE_W-1:0]       line_q [1<<`L1_INDEX_W];

    logic [`L1_INDEX_W-1:0] idx;
    logic [`L1_INDEX_W-1:0] fill_idx;
    logic [`L1_INDEX_W-1:0] inv_idx;
    logic                   hit;
    logic                   accept;
    logic                   op_exec;
    logic                   inv_match;

    assign idx      = if_addr_i[`L1_OFFSET_W +: `L1_INDEX_W];
    assign fill_idx = addr_q[`L1_OFFSET_W +: `L1_INDEX_W];
    assign hit      = valid_q[idx] && (tag_q[idx] == if_addr_i[31 -: `L1_TAG_W]);

    assign if_ready_o = (state_q == S_IDLE);
    assign accept     = if_valid_i && if_ready_o;

    // maintenance waits for an in-flight miss
    assign op_exec   = (op_i || op_pend_q) && (state_q == S_IDLE);
    assign inv_idx   = op_addr_i.index_view.index;
    assign inv_match = (op_kind_i == `OP_KIND_IDX_INV)
                    || (tag_q[inv_idx] == op_addr_i.hit_view.tag);

    assign mem_req_o  = (state_q == S_REQ);
    assign mem_addr_o = {addr_q[31:`L1_OFFSET_W], {`L1_OFFSET_W{1'b0}}};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q          <= S_IDLE;
            valid_q          <= '0;
            op_pend_q        <= 1'b0;
            op_ack_o         <= 1'b0;
            if_rdata_valid_o <= 1'b0;
        end else begin
            if_rdata_valid_o <= 1'b0;
            op_ack_o         <= op_exec;
            op_pend_q        <= (op_pend_q || op_i) && !op_exec;
            case (state_q)
                S_IDLE: begin
                    if (accept && hit) begin
                        if_rdata_valid_o <= 1'b1;
                    end else if (accept) begin
                        state_q <= S_REQ;
                    end
                    if (op_exec && inv_match) begin
                        valid_q[inv_idx] <= 1'b0;
                    end
                end
                S_REQ: begin
                    if (mem_addr_ok_i) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (mem_data_ok_i) begin
                        state_q           <= S_IDLE;
                        valid_q[fill_idx] <= 1'b1;
                        if_rdata_valid_o  <= 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= if_addr_i;
        end
        if (accept && hit) begin
            if_rdata_o <= line_q[idx][{if_addr_i[3:2], 5'b0} +: 32];
        end
        if (state_q == S_WAIT && mem_data_ok_i) begin
            tag_q[fill_idx]  <= addr_q[31 -: `L1_TAG_W];
            line_q[fill_idx] <= mem_rline_i;
            if_rdata_o       <= mem_rline_i[{addr_q[3:2], 5'b0} +: 32]; // critical word
        end
    end

    // a word only follows an accepted fetch or a miss still held off by ready
    a_rdata_after_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        if_rdata_valid_o |-> $past(accept || !if_ready_o));

endmodule

`default_nettype wire

//--- source/dcache.sv
// direct-mapped write-through data cache with byte strobes, refill and invalidation
`timescale 1ns/1ps
`default_nettype none
`include "l1_cache_consts.svh"

module dcache
    import l1_cache_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  ls_valid_i,
    input  logic                  ls_we_i,
    input  logic [31:0]           ls_addr_i,
    input  logic [31:0]           ls_wdata_i,
    input  logic [3:0]            ls_wstrb_i,
    output logic                  ls_ready_o,
    output logic                  ls_rdata_valid_o,
    output logic [31:0]           ls_rdata_o,
    output logic                  ls_wdone_o,
    input  logic                  op_i,
    input  logic                  op_kind_i,
    input  cache_op_addr_u        op_addr_i,
    output logic                  op_ack_o,
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output logic [31:0]           mem_addr_o,
    output logic [31:0]           mem_wdata_o,
    output logic [3:0]            mem_wstrb_o,
    input  logic                  mem_addr_ok_i,
    input  logic                  mem_data_ok_i,
    input  logic [`L1_LINE_W-1:0] mem_rline_i
);
    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_RREQ  = 3'd1;
    localparam logic [2:0] S_RWAIT = 3'd2;
    localparam logic [2:0] S_WREQ  = 3'd3;
    localparam logic [2:0] S_WWAIT = 3'd4;

    logic [2:0]                  state_q;
    logic [31:0]                 addr_q;
    logic [31:0]                 wdata_q;
    logic [3:0]                  wstrb_q;
    logic                        op_pend_q;
    logic [(1<<`L1_INDEX_W)-1:0] valid_q;
    logic [`L1_TAG_W-1:0]        tag_q  [1<<`L1_INDEX_W];
    logic [`L1_LINE_W-1:0]       line_q [1<<`L1_INDEX_W];

    logic [`L1_INDEX_W-1:0] idx;
    logic [`L1_INDEX_W-1:0] fill_idx;
    logic [`L1_INDEX_W-1:0] inv_idx;
    logic                   hit;
    logic                   accept;
    logic                   op_exec;
    logic                   inv_match;
    logic                   fill;

    assign idx      = ls_addr_i[`L1_OFFSET_W +: `L1_INDEX_W];
    assign fill_idx = addr_q[`L1_OFFSET_W +: `L1_INDEX_W];
    assign hit      = valid_q[idx] && (tag_q[idx] == ls_addr_i[31 -: `L1_TAG_W]);
    assign fill     = (state_q == S_RWAIT) && mem_data_ok_i;

    assign ls_ready_o = (state_q == S_IDLE);
    assign accept     = ls_valid_i && ls_ready_o;

    assign op_exec   = (op_i || op_pend_q) && (state_q == S_IDLE);
    assign inv_idx   = op_addr_i.index_view.index;
    assign inv_match = (op_kind_i == `OP_KIND_IDX_INV)
                    || (tag_q[inv_idx] == op_addr_i.hit_view.tag);

    // word write or aligned line read
    assign mem_req_o   = (state_q == S_RREQ) || (state_q == S_WREQ);
    assign mem_we_o    = (state_q == S_WREQ);
    assign mem_addr_o  = mem_we_o ? {addr_q[31:2], 2'b00}
                                  : {addr_q[31:`L1_OFFSET_W], {`L1_OFFSET_W{1'b0}}};
    assign mem_wdata_o = wdata_q;
    assign mem_wstrb_o = wstrb_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q          <= S_IDLE;
            valid_q          <= '0;
            op_pend_q        <= 1'b0;
            op_ack_o         <= 1'b0;
            ls_rdata_valid_o <= 1'b0;
            ls_wdone_o       <= 1'b0;
        end else begin
            ls_rdata_valid_o <= 1'b0;
            ls_wdone_o       <= 1'b0;
            op_ack_o         <= op_exec;
            op_pend_q        <= (op_pend_q || op_i) && !op_exec;
            case (state_q)
                S_IDLE: begin
                    if (accept && ls_we_i) begin
                        state_q <= S_WREQ; // always written through
                    end else if (accept && hit) begin
                        ls_rdata_valid_o <= 1'b1;
                    end else if (accept) begin
                        state_q <= S_RREQ;
                    end
                    if (op_exec && inv_match) begin
                        valid_q[inv_idx] <= 1'b0;
                    end
                end
                S_RREQ:  state_q <= mem_addr_ok_i ? S_RWAIT : S_RREQ;
                S_WREQ:  state_q <= mem_addr_ok_i ? S_WWAIT : S_WREQ;
                S_RWAIT: begin
                    if (mem_data_ok_i) begin
                        state_q           <= S_IDLE;
                        valid_q[fill_idx] <= 1'b1;
                        ls_rdata_valid_o  <= 1'b1;
                    end
                end
                S_WWAIT: begin
                    if (mem_data_ok_i) begin
                        state_q    <= S_IDLE;
                        ls_wdone_o <= 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q  <= ls_addr_i;
            wdata_q <= ls_wdata_i;
            wstrb_q <= ls_wstrb_i;
        end
        if (accept && !ls_we_i && hit) begin
            ls_rdata_o <= line_q[idx][{ls_addr_i[3:2], 5'b0} +: 32];
        end
        // store hit merges bytes, store miss leaves the line alone
        if (accept && ls_we_i && hit) begin
            for (int b = 0; b < 4; b++) begin
                if (ls_wstrb_i[b]) begin
                    line_q[idx][{ls_addr_i[3:2], 5'b0} + 8*b +: 8] <= ls_wdata_i[8*b +: 8];
                end
            end
        end
        if (fill) begin
            tag_q[fill_idx]  <= addr_q[31 -: `L1_TAG_W];
            line_q[fill_idx] <= mem_rline_i;
            ls_rdata_o       <= mem_rline_i[{addr_q[3:2], 5'b0} +: 32];
        end
    end

    a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (mem_req_o && !mem_addr_ok_i) |=> (mem_req_o && $stable(mem_addr_o)));

endmodule

`default_nettype wire

//--- source/mem_arbiter.sv
// fixed-priority merge of icache and dcache requests onto one memory port
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        ic_req_i,
    input  logic [31:0] ic_addr_i,
    input  logic        dc_req_i,
    input  logic        dc_we_i,
    input  logic [31:0] dc_addr_i,
    input  logic [31:0] dc_wdata_i,
    input  logic [3:0]  dc_wstrb_i,
    output logic        mem_req_o,
    output logic        mem_we_o,
    output logic [31:0] mem_addr_o,
    output logic [31:0] mem_wdata_o,
    output logic [3:0]  mem_wstrb_o,
    input  logic        mem_addr_ok_i,
    input  logic        mem_data_ok_i,
    output logic        ic_addr_ok_o,
    output logic        ic_data_ok_o,
    output logic        dc_addr_ok_o,
    output logic        dc_data_ok_o
);
    logic locked_q;
    logic gnt_dc_q;
    logic gnt_dc;

    // dcache wins when idle, grant holds until data_ok
    assign gnt_dc = locked_q ? gnt_dc_q : dc_req_i;

    assign mem_req_o   = gnt_dc ? dc_req_i : ic_req_i;
    assign mem_we_o    = gnt_dc && dc_we_i;
    assign mem_addr_o  = gnt_dc ? dc_addr_i : ic_addr_i;
    assign mem_wdata_o = dc_wdata_i;
    assign mem_wstrb_o = gnt_dc ? dc_wstrb_i : 4'b0000;

    assign ic_addr_ok_o = mem_addr_ok_i && !gnt_dc;
    assign ic_data_ok_o = mem_data_ok_i && !gnt_dc;
    assign dc_addr_ok_o = mem_addr_ok_i && gnt_dc;
    assign dc_data_ok_o = mem_data_ok_i && gnt_dc;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            locked_q <= 1'b0;
            gnt_dc_q <= 1'b0;
        end else if (!locked_q && (ic_req_i || dc_req_i)) begin
            locked_q <= 1'b1;
            gnt_dc_q <= dc_req_i;
        end else if (locked_q && mem_data_ok_i) begin
            locked_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/l1_cache_top.sv
// top level: maintenance controller, both caches and memory arbiter
`timescale 1ns/1ps
`default_nettype none
`include "l1_cache_consts.svh"

module l1_cache_top
    import l1_cache_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // fetch
    input  logic                  if_valid_i,
    input  logic [31:0]           if_addr_i,
    output logic                  if_ready_o,
    output logic                  if_rdata_valid_o,
    output logic [31:0]           if_rdata_o,
    // load and store
    input  logic                  ls_valid_i,
    input  logic                  ls_we_i,
    input  logic [31:0]           ls_addr_i,
    input  logic [31:0]           ls_wdata_i,
    input  logic [3:0]            ls_wstrb_i,
    output logic                  ls_ready_o,
    output logic                  ls_rdata_valid_o,
    output logic [31:0]           ls_rdata_o,
    output logic                  ls_wdone_o,
    // maintenance
    input  logic                  op_valid_i,
    input  logic [1:0]            op_code_i,
    input  logic [31:0]           op_addr_i,
    output logic                  op_busy_o,
    output logic                  op_done_o,
    // memory
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output logic [31:0]           mem_addr_o,
    output logic [31:0]           mem_wdata_o,
    output logic [3:0]            mem_wstrb_o,
    input  logic                  mem_addr_ok_i,
    input  logic                  mem_data_ok_i,
    input  logic [`L1_LINE_W-1:0] mem_rline_i
);
    logic           ic_op;
    logic           dc_op;
    logic           op_kind;
    cache_op_addr_u op_addr;
    logic           ic_ack;
    logic           dc_ack;

    logic        ic_mem_req;
    logic [31:0] ic_mem_addr;
    logic        ic_addr_ok;
    logic        ic_data_ok;
    logic        dc_mem_req;
    logic        dc_mem_we;
    logic [31:0] dc_mem_addr;
    logic [31:0] dc_mem_wdata;
    logic [3:0]  dc_mem_wstrb;
    logic        dc_addr_ok;
    logic        dc_data_ok;

    cache_opctr u_cache_opctr (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .op_valid_i (op_valid_i),
        .op_code_i  (op_code_i),
        .op_addr_i  (op_addr_i),
        .ic_ack_i   (ic_ack),
        .dc_ack_i   (dc_ack),
        .ic_op_o    (ic_op),
        .dc_op_o    (dc_op),
        .op_kind_o  (op_kind),
        .op_addr_o  (op_addr),
        .op_busy_o  (op_busy_o),
        .op_done_o  (op_done_o)
    );

    icache u_icache (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .if_valid_i       (if_valid_i),
        .if_addr_i        (if_addr_i),
        .if_ready_o       (if_ready_o),
        .if_rdata_valid_o (if_rdata_valid_o),
        .if_rdata_o       (if_rdata_o),
        .op_i             (ic_op),
        .op_kind_i        (op_kind),
        .op_addr_i        (op_addr),
        .op_ack_o         (ic_ack),
        .mem_req_o        (ic_mem_req),
        .mem_addr_o       (ic_mem_addr),
        .mem_addr_ok_i    (ic_addr_ok),
        .mem_data_ok_i    (ic_data_ok),
        .mem_rline_i      (mem_rline_i) // shared read line
    );

    dcache u_dcache (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .ls_valid_i       (ls_valid_i),
        .ls_we_i          (ls_we_i),
        .ls_addr_i        (ls_addr_i),
        .ls_wdata_i       (ls_wdata_i),
        .ls_wstrb_i       (ls_wstrb_i),
        .ls_ready_o       (ls_ready_o),
        .ls_rdata_valid_o (ls_rdata_valid_o),
        .ls_rdata_o       (ls_rdata_o),
        .ls_wdone_o       (ls_wdone_o),
        .op_i             (dc_op),
        .op_kind_i        (op_kind),
        .op_addr_i        (op_addr),
        .op_ack_o         (dc_ack),
        .mem_req_o        (dc_mem_req),
        .mem_we_o         (dc_mem_we),
        .mem_addr_o       (dc_mem_addr),
        .mem_wdata_o      (dc_mem_wdata),
        .mem_wstrb_o      (dc_mem_wstrb),
        .mem_addr_ok_i    (dc_addr_ok),
        .mem_data_ok_i    (dc_data_ok),
        .mem_rline_i      (mem_rline_i)
    );

    mem_arbiter u_mem_arbiter (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .ic_req_i      (ic_mem_req),
        .ic_addr_i     (ic_mem_addr),
        .dc_req_i      (dc_mem_req),
        .dc_we_i       (dc_mem_we),
        .dc_addr_i     (dc_mem_addr),
        .dc_wdata_i    (dc_mem_wdata),
        .dc_wstrb_i    (dc_mem_wstrb),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_wstrb_o   (mem_wstrb_o),
        .mem_addr_ok_i (mem_addr_ok_i),
        .mem_data_ok_i (mem_data_ok_i),
        .ic_addr_ok_o  (ic_addr_ok),
        .ic_data_ok_o  (ic_data_ok),
        .dc_addr_ok_o  (dc_addr_ok),
        .dc_data_ok_o  (dc_data_ok)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
// testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o; // 40 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #2;
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/tb_l1_cache.sv
// testbench top with memory model, directed tests for both caches and maintenance, check task
`timescale 1ns/1ps
`default_nettype none
`include "l1_cache_consts.svh"

module tb_l1_cache;
    localparam int TMO = 200;

    logic                  clk;
    logic                  arst_n;
    logic                  if_valid;
    logic [31:0]           if_addr;
    logic                  if_ready;
    logic                  if_rdata_valid;
    logic [31:0]           if_rdata;
    logic                  ls_valid;
    logic                  ls_we;
    logic [31:0]           ls_addr;
    logic [31:0]           ls_wdata;
    logic [3:0]            ls_wstrb;
    logic                  ls_ready;
    logic                  ls_rdata_valid;
    logic [31:0]           ls_rdata;
    logic                  ls_wdone;
    logic                  op_valid;
    logic [1:0]            op_code;
    logic [31:0]           op_addr;
    logic                  op_busy;
    logic                  op_done;
    logic                  mem_req;
    logic                  mem_we;
    logic [31:0]           mem_addr;
    logic [31:0]           mem_wdata;
    logic [3:0]            mem_wstrb;
    logic                  mem_addr_ok;
    logic                  mem_data_ok;
    logic [`L1_LINE_W-1:0] mem_rline;

    // memory contents and the values the tests expect
    logic [31:0] mem_q    [logic [31:0]];
    logic [31:0] shadow_q [logic [31:0]];
    logic [31:0] acc_q    [$]; // accepted memory addresses
    int          rd_cnt;
    int          done_cnt;

    logic        m_we;
    logic [31:0] m_addr;
    logic [31:0] m_wdata;
    logic [3:0]  m_strb;
    int unsigned m_dly;

    tb_clock_gen u_clock_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    l1_cache_top u_l1_cache_top (
        .clk_i            (clk),
        .arst_n_i         (arst_n),
        .if_valid_i       (if_valid),
        .if_addr_i        (if_addr),
        .if_ready_o       (if_ready),
        .if_rdata_valid_o (if_rdata_valid),
        .if_rdata_o       (if_rdata),
        .ls_valid_i       (ls_valid),
        .ls_we_i          (ls_we),
        .ls_addr_i        (ls_addr),
        .ls_wdata_i       (ls_wdata),
        .ls_wstrb_i       (ls_wstrb),
        .ls_ready_o       (ls_ready),
        .ls_rdata_valid_o (ls_rdata_valid),
        .ls_rdata_o       (ls_rdata),
        .ls_wdone_o       (ls_wdone),
        .op_valid_i       (op_valid),
        .op_code_i        (op_code),
        .op_addr_i        (op_addr),
        .op_busy_o        (op_busy),
        .op_done_o        (op_done),
        .mem_req_o        (mem_req),
        .mem_we_o         (mem_we),
        .mem_addr_o       (mem_addr),
        .mem_wdata_o      (mem_wdata),
        .mem_wstrb_o      (mem_wstrb),
        .mem_addr_ok_i    (mem_addr_ok),
        .mem_data_ok_i    (mem_data_ok),
        .mem_rline_i      (mem_rline)
    );

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wd,
                                          input logic [3:0] sb);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (sb[b])
                r[8*b +: 8] = wd[8*b +: 8];
        end
        return r;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        if (mem_q.exists(a))
            return mem_q[a];
        return fill_word(a);
    endfunction

    function automatic logic [31:0] exp_word(input logic [31:0] a);
        if (shadow_q.exists(a))
            return shadow_q[a];
        return fill_word(a);
    endfunction

    // addr ok after 0..3 cycles, data ok 1..4 cycles later
    always begin : mem_model
        @(posedge clk);
        #2;
        if (arst_n && mem_req) begin
            m_dly = $urandom_range(3, 0);
            repeat (m_dly) begin
                @(posedge clk);
                #2;
            end
            mem_addr_ok = 1'b1;
            m_we        = mem_we;
            m_addr      = mem_addr;
            m_wdata     = mem_wdata;
            m_strb      = mem_wstrb;
            acc_q.push_back(mem_addr);
            @(posedge clk);
            #2;
            mem_addr_ok = 1'b0;
            m_dly = $urandom_range(4, 1);
            repeat (m_dly - 1) begin
                @(posedge clk);
                #2;
            end
            if (m_we) begin
                mem_q[m_addr] = merge(mem_word(m_addr), m_wdata, m_strb);
            end else begin
                for (int w = 0; w < 4; w++) begin
                    mem_rline[32*w +: 32] = mem_word(m_addr + 32'(4 * w));
                end
                rd_cnt++;
            end
            mem_data_ok = 1'b1;
            @(posedge clk);
            #2;
            mem_data_ok = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (op_done)
            done_cnt++;
    end

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(input logic [31:0] act, input logic [31:0] exp, input string name);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, act, exp);
            stop_run();
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic tick(inout int n, input string what);
        step();
        n++;
        if (n > TMO) begin
            $display("timeout while waiting: %s", what);
            stop_run();
        end
    endtask

    task automatic fetch(input logic [31:0] a, output logic [31:0] d);
        int n;
        n = 0;
        while (!if_ready)
            tick(n, "if_ready_o never rose");
        if_valid = 1'b1;
        if_addr  = a;
        step();
        if_valid = 1'b0;
        n = 0;
        while (!if_rdata_valid)
            tick(n, "no if_rdata_valid_o after fetch");
        d = if_rdata;
    endtask

    task automatic load(input logic [31:0] a, output logic [31:0] d);
        int n;
        n = 0;
        while (!ls_ready)
            tick(n, "ls_ready_o never rose");
        ls_valid = 1'b1;
        ls_we    = 1'b0;
        ls_addr  = a;
        step();
        ls_valid = 1'b0;
        n = 0;
        while (!ls_rdata_valid)
            tick(n, "no ls_rdata_valid_o after load");
        d = ls_rdata;
    endtask

    task automatic store(input logic [31:0] a, input logic [31:0] wd, input logic [3:0] sb);
        int n;
        n = 0;
        shadow_q[a] = merge(exp_word(a), wd, sb);
        while (!ls_ready)
            tick(n, "ls_ready_o never rose");
        ls_valid = 1'b1;
        ls_we    = 1'b1;
        ls_addr  = a;
        ls_wdata = wd;
        ls_wstrb = sb;
        step();
        ls_valid = 1'b0;
        ls_we    = 1'b0;
        n = 0;
        while (!ls_wdone)
            tick(n, "no ls_wdone_o after store");
    endtask

    task automatic run_op(input logic [1:0] code, input logic [31:0] a);
        int n;
        int d0;
        n  = 0;
        d0 = done_cnt;
        while (op_busy)
            tick(n, "op_busy_o stuck high");
        op_valid = 1'b1;
        op_code  = code;
        op_addr  = a;
        step();
        op_valid = 1'b0;
        n = 0;
        while (done_cnt == d0)
            tick(n, "no op_done_o pulse");
        step();
        step();
        check_eq(32'(done_cnt - d0), 32'd1, "op_done_o pulse count");
        check_eq(32'(op_busy), 32'd0, "op_busy_o");
    endtask

    // fetch on the icache, load on the dcache
    task automatic access(input logic tgt, input logic [31:0] a, input int reads);
        logic [31:0] d;
        int          r0;
        r0 = rd_cnt;
        if (tgt == `OP_TGT_DCACHE)
            load(a, d);
        else
            fetch(a, d);
        check_eq(d, exp_word(a), "read data");
        check_eq(32'(rd_cnt - r0), 32'(reads), "memory reads");
    endtask

    task automatic reset_values();
        check_eq(32'(if_ready), 32'd1, "if_ready_o");
        check_eq(32'(ls_ready), 32'd1, "ls_ready_o");
        check_eq(32'(op_busy), 32'd0, "op_busy_o");
        check_eq(32'(mem_req), 32'd0, "mem_req_o");
    endtask

    task automatic fetch_reuse();
        access(`OP_TGT_ICACHE, 32'h0000_1004, 1);
        check_eq(acc_q[acc_q.size()-1], 32'h0000_1000, "mem_addr_o");
        access(`OP_TGT_ICACHE, 32'h0000_1008, 0); // same line
    endtask

    task automatic store_load_merge();
        access(`OP_TGT_DCACHE, 32'h0000_2000, 1);
        store(32'h0000_2004, 32'hdead_beef, 4'b0110);
        check_eq(mem_word(32'h0000_2004), exp_word(32'h0000_2004), "memory word after store");
        access(`OP_TGT_DCACHE, 32'h0000_2004, 0);
        store(32'h0000_2150, 32'h1234_5678, 4'b1111); // store miss does not allocate
        access(`OP_TGT_DCACHE, 32'h0000_2150, 1);
    endtask

    task automatic invalidate_ops(input logic tgt, input logic [31:0] a);
        access(tgt, a, 1);
        run_op({`OP_KIND_HIT_INV, tgt}, a ^ 32'h0010_0000);
        access(tgt, a, 0);
        run_op({`OP_KIND_HIT_INV, tgt}, a);
        access(tgt, a, 1);
        run_op({`OP_KIND_IDX_INV, tgt}, a ^ 32'hfff0_0000);
        access(tgt, a, 1);
    endtask

    task automatic dual_miss();
        logic [31:0] di;
        logic [31:0] dd;
        acc_q.delete();
        fork
            fetch(32'h0000_4000, di);
            load(32'h0000_5010, dd);
        join
        check_eq(di, exp_word(32'h0000_4000), "if_rdata_o");
        check_eq(dd, exp_word(32'h0000_5010), "ls_rdata_o");
        check_eq(acc_q[0], 32'h0000_5010, "first accepted mem_addr_o");
    endtask

    task automatic random_mix();
        logic [31:0] a;
        logic [31:0] d;
        int unsigned kind;
        for (int i = 0; i < 200; i++) begin
            kind = $urandom_range(2, 0);
            // two tags alias onto each index
            a = 32'h0000_6000 + 32'h400 * $urandom_range(1, 0) + 4 * $urandom_range(63, 0);
            if (kind == 0) begin
                a = a + 32'h1000; // code region is never stored to
                fetch(a, d);
                check_eq(d, exp_word(a), "if_rdata_o");
            end else if (kind == 1) begin
                load(a, d);
                check_eq(d, exp_word(a), "ls_rdata_o");
            end else begin
                store(a, $urandom, 4'($urandom_range(15, 1)));
            end
        end
    endtask

    initial begin : main
        int n;
        if_valid    = 1'b0;
        if_addr     = '0;
        ls_valid    = 1'b0;
        ls_we       = 1'b0;
        ls_addr     = '0;
        ls_wdata    = '0;
        ls_wstrb    = '0;
        op_valid    = 1'b0;
        op_code     = '0;
        op_addr     = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rline   = '0;
        rd_cnt      = 0;
        done_cnt    = 0;
        void'($urandom(32'he9a3_850c));
        n = 0;
        while (arst_n !== 1'b1)
            tick(n, "reset never released");
        step();
        reset_values();
        fetch_reuse();
        store_load_merge();
        invalidate_ops(`OP_TGT_ICACHE, 32'h0000_3040);
        invalidate_ops(`OP_TGT_DCACHE, 32'h0000_3080);
        dual_miss();
        random_mix();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
source/l1_cache_pkg.sv
source/cache_opctr.sv
source/icache.sv
source/dcache.sv
source/mem_arbiter.sv
source/l1_cache_top.sv
bench/tb_clock_gen.sv
bench/tb_l1_cache.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_l1_cache -o sim_l1_cache

./obj_dir/sim_l1_cache > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then
    exit 1
fi
